//--- source/isa_pkg.sv
/*
   isa_pkg
   instruction-set constants for the 16-bit fetch unit. Holds word and field
   types, flow-control opcodes and the memory sizes.
*/
`default_nettype none

package isa_pkg;

   // data, instruction and address width
   localparam int WORD_W = 16;
   // register file
   localparam int REG_COUNT = 8;
   localparam int REG_AW = $clog2(REG_COUNT);
   // instruction store, in words
   localparam int IMEM_WORDS = 256;
   localparam int IMEM_AW = $clog2(IMEM_WORDS);

   // opcode sits in bits 15..11
   localparam int OPC_W = 5;
   // branch / jr immediate in bits 7..0
   localparam int IMM8_W = 8;
   // j displacement in bits 10..0
   localparam int DISP_W = 11;

   typedef logic [WORD_W-1:0] word_t;
   typedef logic [REG_AW-1:0] reg_idx_t;
   typedef logic [OPC_W-1:0] opcode_t;
   // word index into the instruction store
   typedef logic [IMEM_AW-1:0] imem_idx_t;

   // pc comes out of reset here
   localparam word_t RESET_PC = '0;
   // byte addressed, word aligned
   localparam word_t PC_STEP = 16'd2;

   // machine control
   localparam opcode_t OP_HALT = 5'b00000;
   localparam opcode_t OP_NOP = 5'b00001;

   // pc-relative jump, 11-bit displacement
   localparam opcode_t OP_J = 5'b00100;
   // register jump, rs plus 8-bit immediate
   localparam opcode_t OP_JR = 5'b00101;

   // conditional branches on rs against zero
   localparam opcode_t OP_BEQZ = 5'b01100;
   localparam opcode_t OP_BNEZ = 5'b01101;
   localparam opcode_t OP_BLTZ = 5'b01110;
   localparam opcode_t OP_BGEZ = 5'b01111;

endpackage

`default_nettype wire

//--- source/fetch_pkg.sv
/*
   fetch_pkg
   control-flow decision passed from flow decode to the fetch stage
*/
`default_nettype none

package fetch_pkg;

   // one decision per cycle, all combinational from the current instr
   typedef struct packed {
      // freeze pc, set the sticky halted level
      logic halt;
      // jump decoded or branch taken
      logic redirect;
      // target base is rs instead of pc+2
      logic reg_base;
      // sign-extended displacement, added unshifted
      isa_pkg::word_t offset;
   } flow_ctrl_t;

   // decision for any non-flow word: just advance
   localparam flow_ctrl_t FLOW_NONE = '{
      halt: 1'b0,
      redirect: 1'b0,
      reg_base: 1'b0,
      offset: '0
   };

endpackage

`default_nettype wire

//--- source/instr_mem.sv
/*
   instr_mem
   word-addressed instruction store. Combinational read at pc, and a
   synchronous load port for filling programs from outside.
*/
`timescale 1ns/1ns
`default_nettype none

module instr_mem (
   input wire logic clk,
   // load port, one word per edge
   input wire logic imem_load_en,
   input wire isa_pkg::imem_idx_t imem_load_addr,
   input wire isa_pkg::word_t imem_load_data,
   // fetch side
   input wire isa_pkg::word_t pc,
   output isa_pkg::word_t instr
);

   import isa_pkg::*;

   // program storage, kept across rst
   word_t mem [IMEM_WORDS];

   // byte address to word index, bit 0 ignored
   imem_idx_t rd_idx;

   assign rd_idx = pc[IMEM_AW:1];

   // load strobe writes at the rising edge
   always_ff @(posedge clk) begin
      if (imem_load_en) begin
         mem[imem_load_addr] <= imem_load_data;
      end
   end

   // async read, pc to instr in the same cycle
   assign instr = mem[rd_idx];

endmodule

`default_nettype wire

//--- source/reg_file.sv
/*
   reg_file
   eight 16-bit registers. One async read port for Rs, one synchronous
   write port. No write-to-read bypass.
*/
`timescale 1ns/1ns
`default_nettype none

module reg_file (
   input wire logic clk,
   input wire logic rst,
   // write port, brought out for presetting
   input wire logic reg_wr_en,
   input wire isa_pkg::reg_idx_t reg_wr_idx,
   input wire isa_pkg::word_t reg_wr_data,
   // rs read port
   input wire isa_pkg::reg_idx_t rs_idx,
   output isa_pkg::word_t rs_data
);

   import isa_pkg::*;

   word_t regs [REG_COUNT];

   // rst zeroes every register, else one write per edge
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < REG_COUNT; i++) begin
            regs[i] <= '0;
         end
      end else if (reg_wr_en) begin
         regs[reg_wr_idx] <= reg_wr_data;
      end
   end

   // read sees the stored value, so a same-cycle write shows up next cycle
   assign rs_data = regs[rs_idx];

endmodule

`default_nettype wire

//--- source/flow_decode.sv
/*
   flow_decode
   decodes flow-control opcodes only. Sign-extends the j / branch offsets and
   tests Rs against zero to resolve the four conditional branches.
*/
`timescale 1ns/1ns
`default_nettype none

module flow_decode (
   input wire isa_pkg::word_t instr,
   // value of the rs register for this instr
   input wire isa_pkg::word_t rs_data,
   output isa_pkg::reg_idx_t rs_idx,
   output fetch_pkg::flow_ctrl_t flow
);

   import isa_pkg::*;
   import fetch_pkg::*;

   opcode_t opcode;
   // both offset forms widened to a full word
   word_t imm8_ext;
   word_t disp11_ext;
   // rs condition flags
   logic rs_zero;
   logic rs_neg;

   // fixed fields
   assign opcode = instr[WORD_W-1 -: OPC_W];
   assign rs_idx = instr[10:8];

   // offsets are sign-extended and stay in bytes
   assign imm8_ext = {{(WORD_W-IMM8_W){instr[IMM8_W-1]}}, instr[IMM8_W-1:0]};
   assign disp11_ext = {{(WORD_W-DISP_W){instr[DISP_W-1]}}, instr[DISP_W-1:0]};

   assign rs_zero = (rs_data == '0);
   // two's complement sign bit
   assign rs_neg = rs_data[WORD_W-1];

   always_comb begin
      // anything not listed just advances pc, nop included
      flow = FLOW_NONE;
      case (opcode)
         OP_HALT: begin
            flow.halt = 1'b1;
         end
         OP_J: begin
            flow.redirect = 1'b1;
            flow.offset = disp11_ext;
         end
         OP_JR: begin
            // target is rs + imm rather than pc-relative
            flow.redirect = 1'b1;
            flow.reg_base = 1'b1;
            flow.offset = imm8_ext;
         end
         OP_BEQZ: begin
            flow.redirect = rs_zero;
            flow.offset = imm8_ext;
         end
         OP_BNEZ: begin
            flow.redirect = !rs_zero;
            flow.offset = imm8_ext;
         end
         OP_BLTZ: begin
            flow.redirect = rs_neg;
            flow.offset = imm8_ext;
         end
         OP_BGEZ: begin
            // zero counts as non-negative
            flow.redirect = !rs_neg;
            flow.offset = imm8_ext;
         end
         default: begin
            flow = FLOW_NONE;
         end
      endcase
   end

endmodule

`default_nettype wire

//--- source/fetch.sv
/*
   fetch
   pc register with pc+2 and target adders. Picks one next pc per cycle,
   holds on stall, and on HALT freezes pc with a sticky halted level.
*/
`timescale 1ns/1ns
`default_nettype none

module fetch (
   input wire logic clk,
   input wire logic rst,
   // hold pc this edge
   input wire logic stall,
   input wire fetch_pkg::flow_ctrl_t flow,
   // base for register jumps
   input wire isa_pkg::word_t rs_data,
   output isa_pkg::word_t pc,
   output logic halted
);

   import isa_pkg::*;

   word_t pc_plus2;
   word_t target_base;
   word_t target;
   word_t next_pc;
   logic hold;

   // sequential address, wraps at 2^16
   assign pc_plus2 = pc + PC_STEP;

   // jr uses rs, everything else is relative to pc+2
   assign target_base = flow.reg_base ? rs_data : pc_plus2;
   assign target = target_base + flow.offset;

   // stall, an earlier halt, or a halt now all keep pc
   assign hold = stall || halted || flow.halt;

   always_comb begin
      if (hold) begin
         next_pc = pc;
      end else if (flow.redirect) begin
         next_pc = target;
      end else begin
         next_pc = pc_plus2;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         pc <= RESET_PC;
         halted <= 1'b0;
      end else begin
         pc <= next_pc;
         // sticky until rst, stall masks a halt in flight
         if (flow.halt && !stall) begin
            halted <= 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

//--- source/fetch_top.sv
/*
   fetch_top
   fetch side of the 16-bit core: pc, instruction store, register file
   and flow decode, with load ports brought out
*/
`timescale 1ns/1ns
`default_nettype none

module fetch_top (
   input wire logic clk,
   input wire logic rst,
   input wire logic stall,
   // program load
   input wire logic imem_load_en,
   input wire isa_pkg::imem_idx_t imem_load_addr,
   input wire isa_pkg::word_t imem_load_data,
   // register preset
   input wire logic reg_wr_en,
   input wire isa_pkg::reg_idx_t reg_wr_idx,
   input wire isa_pkg::word_t reg_wr_data,
   output isa_pkg::word_t pc,
   output isa_pkg::word_t instr,
   output logic halted
);

   import isa_pkg::*;
   import fetch_pkg::*;

   // rs lookup between decode and register file
   reg_idx_t rs_idx;
   word_t rs_data;
   // decode result into fetch
   flow_ctrl_t flow;

   fetch fetch_i (
      .clk(clk),
      .rst(rst),
      .stall(stall),
      .flow(flow),
      .rs_data(rs_data),
      .pc(pc),
      .halted(halted)
   );

   instr_mem instr_mem_i (
      .clk(clk),
      .imem_load_en(imem_load_en),
      .imem_load_addr(imem_load_addr),
      .imem_load_data(imem_load_data),
      .pc(pc),
      .instr(instr)
   );

   reg_file reg_file_i (
      .clk(clk),
      .rst(rst),
      .reg_wr_en(reg_wr_en),
      .reg_wr_idx(reg_wr_idx),
      .reg_wr_data(reg_wr_data),
      .rs_idx(rs_idx),
      .rs_data(rs_data)
   );

   flow_decode flow_decode_i (
      .instr(instr),
      .rs_data(rs_data),
      .rs_idx(rs_idx),
      .flow(flow)
   );

endmodule

`default_nettype wire

//--- testbench/clock_gen.sv
/*
   clock_gen
   free-running 100 ns clock for the fetch testbench
*/
`timescale 1ns/1ns
`default_nettype none

module clock_gen (
   output logic clk
);

   // half of the 100 ns period
   localparam int HALF_NS = 50;

   initial begin
      clk = 1'b0;
   end

   always #(HALF_NS) clk = ~clk;

endmodule

`default_nettype wire

//--- testbench/fetch_tb.sv
/*
   fetch_tb
   directed tests for the fetch side covering sequential fetch, stall, jumps,
   branches on Rs, register jumps and HALT against a cycle model
*/
`timescale 1ns/1ns
`default_nettype none

module fetch_tb;

   import isa_pkg::*;

   localparam int RESET_CYCLES = 16;
   // tests take about 170 edges and the limit doubles that with room to spare
   localparam int TEST_CYCLES = 200;
   localparam int CYCLE_LIMIT = 2 * (RESET_CYCLES + TEST_CYCLES);

   logic clk;
   logic rst;
   logic stall;
   logic imem_load_en;
   imem_idx_t imem_load_addr;
   word_t imem_load_data;
   logic reg_wr_en;
   reg_idx_t reg_wr_idx;
   word_t reg_wr_data;
   word_t pc;
   word_t instr;
   logic halted;

   // reference copies of memory and registers
   word_t model_mem [256];
   word_t model_regs [8];
   // predicted outputs for the coming negedge
   word_t exp_pc;
   logic exp_halted;
   // off until the first edge with rst high
   logic checking = 1'b0;
   int cycle_count = 0;
   logic [31:0] lfsr = 32'h5d7b_88be;

   clock_gen clock_gen_i (
      .clk(clk)
   );

   fetch_top fetch_top_i (
      .clk(clk),
      .rst(rst),
      .stall(stall),
      .imem_load_en(imem_load_en),
      .imem_load_addr(imem_load_addr),
      .imem_load_data(imem_load_data),
      .reg_wr_en(reg_wr_en),
      .reg_wr_idx(reg_wr_idx),
      .reg_wr_data(reg_wr_data),
      .pc(pc),
      .instr(instr),
      .halted(halted)
   );

   // galois lfsr stepped once per bit, each bit shifted in at the bottom
   function automatic word_t lfsr_bits(input int n);
      word_t r;
      logic lsb;
      r = '0;
      for (int i = 0; i < n; i++) begin
         lsb = lfsr[0];
         lfsr = lfsr >> 1;
         if (lsb) begin
            lfsr = lfsr ^ 32'h8020_0003;
         end
         r = {r[14:0], lsb};
      end
      return r;
   endfunction

   function automatic word_t sext8(input logic [7:0] v);
      return {{8{v[7]}}, v};
   endfunction

   function automatic word_t sext11(input logic [10:0] v);
      return {{5{v[10]}}, v};
   endfunction

   // any word with the top opcode bit set is outside the flow set
   function automatic word_t plain_word();
      word_t w;
      w = lfsr_bits(16);
      w[15] = 1'b1;
      return w;
   endfunction

   // next pc from the fetch rules with rst left to the caller
   function automatic word_t predict_pc(input word_t cur, input word_t word,
                                        input logic was_halted, input logic stalled);
      word_t seq;
      word_t rs_val;
      word_t imm;
      seq = cur + 16'd2;
      rs_val = model_regs[word[10:8]];
      imm = sext8(word[7:0]);
      if (stalled || was_halted) begin
         return cur;
      end
      case (word[15:11])
         OP_HALT: return cur;
         OP_J: return seq + sext11(word[10:0]);
         OP_JR: return rs_val + imm;
         OP_BEQZ: return (rs_val == 16'd0) ? seq + imm : seq;
         OP_BNEZ: return (rs_val != 16'd0) ? seq + imm : seq;
         OP_BLTZ: return rs_val[15] ? seq + imm : seq;
         OP_BGEZ: return !rs_val[15] ? seq + imm : seq;
         default: return seq;
      endcase
   endfunction

   task automatic report_mismatch(input string what, input word_t got, input word_t want);
      $display("ERROR [%0t] %s mismatch: got %h, expected %h", $time, what, got, want);
      $display("CHECKS FAILED");
      $fatal(1, "stopping at first error");
   endtask

   // check at negedge and predict across the next rising edge
   task automatic step_cycle();
      word_t word;
      word_t nxt_pc;
      logic nxt_halted;
      logic in_rst;
      logic ld_en;
      imem_idx_t ld_addr;
      word_t ld_data;
      logic wr_en;
      reg_idx_t wr_idx;
      word_t wr_data;
      @(negedge clk);
      // word index is pc bits 8..1
      word = model_mem[exp_pc[8:1]];
      if (checking) begin
         assert (pc === exp_pc) else report_mismatch("pc", pc, exp_pc);
         assert (instr === word) else report_mismatch("instr", instr, word);
         assert (halted === exp_halted)
            else report_mismatch("halted", {15'd0, halted}, {15'd0, exp_halted});
      end
      // inputs are stable here so capture what the edge will see
      in_rst = rst;
      ld_en = imem_load_en;
      ld_addr = imem_load_addr;
      ld_data = imem_load_data;
      wr_en = reg_wr_en;
      wr_idx = reg_wr_idx;
      wr_data = reg_wr_data;
      if (in_rst) begin
         nxt_pc = RESET_PC;
         nxt_halted = 1'b0;
      end else begin
         nxt_pc = predict_pc(exp_pc, word, exp_halted, stall);
         nxt_halted = exp_halted || ((word[15:11] == OP_HALT) && !stall);
      end
      @(posedge clk);
      exp_pc = nxt_pc;
      exp_halted = nxt_halted;
      if (ld_en) begin
         model_mem[ld_addr] = ld_data;
      end
      // rst wins over a register write
      if (in_rst) begin
         for (int i = 0; i < 8; i++) begin
            model_regs[i] = '0;
         end
         checking = 1'b1;
      end else if (wr_en) begin
         model_regs[wr_idx] = wr_data;
      end
   endtask

   task automatic apply_reset(input int n);
      rst <= 1'b1;
      stall <= 1'b1;
      repeat (n) step_cycle();
      rst <= 1'b0;
   endtask

   task automatic load_word(input imem_idx_t idx, input word_t data);
      imem_load_en <= 1'b1;
      imem_load_addr <= idx;
      imem_load_data <= data;
      step_cycle();
      imem_load_en <= 1'b0;
   endtask

   task automatic write_reg(input reg_idx_t idx, input word_t data);
      reg_wr_en <= 1'b1;
      reg_wr_idx <= idx;
      reg_wr_data <= data;
      step_cycle();
      reg_wr_en <= 1'b0;
   endtask

   // n free edges with stall back on afterwards
   task automatic run_cycles(input int n);
      stall <= 1'b0;
      repeat (n) step_cycle();
      stall <= 1'b1;
   endtask

   task automatic sequential_fetch();
      for (int i = 0; i < 10; i++) begin
         load_word(8'(i), plain_word());
      end
      run_cycles(8);
   endtask

   // words 0..9 still hold the non-flow run
   task automatic stall_hold();
      apply_reset(2);
      run_cycles(3);
      repeat (4) step_cycle();
      run_cycles(3);
   endtask

   task automatic relative_jumps();
      // 0 to 8 is forward by 6
      load_word(8'd0, {OP_J, 11'd6});
      // 8 to 2 is back by 8
      load_word(8'd4, {OP_J, 11'h7f8});
      // 2 to fff0 goes back by 20 across address 0
      load_word(8'd1, {OP_J, 11'h7ec});
      // fff0 to 6 goes forward by 20 and wraps to the bottom
      load_word(8'd248, {OP_J, 11'd20});
      load_word(8'd3, {OP_HALT, 11'd0});
      apply_reset(2);
      run_cycles(6);
   endtask

   task automatic conditional_branches();
      opcode_t ops [4];
      reg_idx_t rs;
      logic [7:0] imm;
      word_t val;
      ops[0] = OP_BEQZ;
      ops[1] = OP_BNEZ;
      ops[2] = OP_BLTZ;
      ops[3] = OP_BGEZ;
      for (int b = 0; b < 4; b++) begin
         for (int k = 0; k < 4; k++) begin
            rs = 3'(lfsr_bits(3));
            imm = 8'(lfsr_bits(8));
            imm[0] = 1'b0;
            val = lfsr_bits(16);
            // zero, positive, negative, then anything
            case (k)
               0: val = '0;
               1: val = {1'b0, val[14:0] | 15'd1};
               2: val[15] = 1'b1;
               default: ;
            endcase
            load_word(8'd0, {ops[b], rs, imm});
            apply_reset(2);
            write_reg(rs, val);
            run_cycles(1);
         end
      end
      step_cycle();
   endtask

   task automatic register_jump();
      reg_idx_t rs;
      logic [7:0] imm;
      word_t base;
      for (int k = 0; k < 3; k++) begin
         rs = 3'(lfsr_bits(3));
         imm = 8'(lfsr_bits(8)) & 8'hfe;
         base = lfsr_bits(16) & 16'hfffe;
         load_word(8'd0, {OP_JR, rs, imm});
         apply_reset(2);
         write_reg(rs, base);
         run_cycles(1);
      end
      // r5 is rewritten on the jump edge but the target stays 0x0120 + 0x10
      load_word(8'd0, {OP_JR, 3'd5, 8'h10});
      apply_reset(2);
      write_reg(3'd5, 16'h0120);
      reg_wr_en <= 1'b1;
      reg_wr_idx <= 3'd5;
      reg_wr_data <= 16'h0400;
      stall <= 1'b0;
      step_cycle();
      reg_wr_en <= 1'b0;
      stall <= 1'b1;
      step_cycle();
   endtask

   task automatic halt_then_reset();
      load_word(8'd0, plain_word());
      load_word(8'd1, plain_word());
      load_word(8'd2, {OP_HALT, 11'h2a5});
      load_word(8'd3, plain_word());
      apply_reset(2);
      // 0, 2, then the halt at 4 freezes pc
      run_cycles(4);
      for (int i = 0; i < 6; i++) begin
         stall <= 1'(lfsr_bits(1));
         step_cycle();
      end
      stall <= 1'b1;
      // program is still there after rst
      apply_reset(2);
      run_cycles(2);
      // halt seen under stall leaves halted low
      repeat (2) step_cycle();
      run_cycles(1);
      step_cycle();
   endtask

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= CYCLE_LIMIT) begin
         $display("timeout: the run went past %0d cycles without finishing", CYCLE_LIMIT);
         $display("CHECKS FAILED");
         $fatal(1, "timeout");
      end
   end

   initial begin
      rst = 1'b1;
      stall = 1'b1;
      imem_load_en = 1'b0;
      imem_load_addr = '0;
      imem_load_data = '0;
      reg_wr_en = 1'b0;
      reg_wr_idx = '0;
      reg_wr_data = '0;
      @(posedge clk);
      apply_reset(RESET_CYCLES);
      sequential_fetch();
      stall_hold();
      relative_jumps();
      conditional_branches();
      register_jump();
      halt_then_reset();
      $display("ALL CHECKS PASSED");
      $finish;
   end

endmodule

`default_nettype wire

//--- files.f
source/isa_pkg.sv
source/fetch_pkg.sv
source/instr_mem.sv
source/reg_file.sv
source/flow_decode.sv
source/fetch.sv
source/fetch_top.sv
testbench/clock_gen.sv
testbench/fetch_tb.sv
